//--- common/robPkg.sv
package robPkg;

    // buffer geometry, bound to the 6-bit sequence space
    localparam int RobLength = 16;
    localparam int RobIdxW = $clog2(RobLength);
    localparam int CommitWidth = 2;
    localparam int WbWidth = 2;

    // sequence numbers wrap at 64 and are compared as signed differences
    typedef logic [5:0] SqN;

    typedef enum logic [1:0] {
        FlagNone   = 2'd0,
        FlagBreak  = 2'd1,
        FlagTrap   = 2'd2,
        FlagExcept = 2'd3
    } Flags;

    typedef struct packed {
        logic valid;
        logic [4:0] nmDst;
        SqN tagDst;
        SqN sqN;
        logic [31:0] pc;
        logic isBranch;
        logic branchTaken;
        logic [5:0] branchId;
    } CommitUOp;

    // redirect from the buffer, flush is always set
    typedef struct packed {
        logic taken;
        logic [31:0] dstPc;
        SqN sqN;
        logic flush;
        SqN storeSqN;
        SqN loadSqN;
    } BranchProv;

endpackage

//--- common/uopPkg.sv
package uopPkg;

    import robPkg::*;

    // depth of the multiply pipeline
    localparam int MulStages = 3;

    // codes not listed here decode as illegal
    typedef enum logic [3:0] {
        OpAdd     = 4'd0,
        OpMul     = 4'd1,
        OpBranch  = 4'd2,
        OpEbreak  = 4'd3,
        OpEcall   = 4'd4,
        OpIllegal = 4'd15
    } Opcode;

    // raw instruction word, msb first
    typedef struct packed {
        logic [3:0] opcode;
        logic [4:0] nmDst;
        logic [7:0] opA;
        logic [7:0] opB;
        logic [5:0] branchId;
        logic spare;
    } InstrWord;

    typedef struct packed {
        logic valid;
        Opcode opcode;
        logic [4:0] nmDst;
        SqN tagDst;
        SqN sqN;
        logic [31:0] pc;
        logic [7:0] opA;
        logic [7:0] opB;
        logic [5:0] branchId;
    } DecUOp;

    // result as written back into the reorder buffer
    typedef struct packed {
        logic valid;
        Flags flags;
        logic [4:0] nmDst;
        SqN tagDst;
        SqN sqN;
        logic [31:0] pc;
        logic isBranch;
        logic branchTaken;
        logic [5:0] branchId;
    } ResUOp;

endpackage

//--- design/backendTop.sv
`timescale 1ns/1ps

module backendTop import robPkg::*; import uopPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic instrValid,
    input  logic [31:0] instrPc,
    input  logic [31:0] instr,
    input  logic [31:0] irqAddr,
    output logic stall,
    output CommitUOp commits [CommitWidth-1:0],
    output BranchProv branch,
    output Flags irqFlags,
    output logic [31:0] irqSrc,
    output logic [11:0] irqMemAddr,
    output logic halt
);

    DecUOp decUop;
    ResUOp wbUop [WbWidth-1:0];
    SqN curSqN;

    uopDecode decode (
        .clk(clk),
        .rst(rst),
        .instrValid(instrValid),
        .instrPc(instrPc),
        .instr(instr),
        .curSqN(curSqN),
        .branch(branch),
        .decUop(decUop),
        .stall(stall)
    );

    execUnits execute (
        .clk(clk),
        .rst(rst),
        .decUop(decUop),
        .branch(branch),
        .wbUop(wbUop)
    );

    // decode derives the window end from curSqN, so maxSqN stays open
    reorderBuffer rob (
        .clk(clk),
        .rst(rst),
        .wbUop(wbUop),
        .irqAddr(irqAddr),
        .curSqN(curSqN),
        .maxSqN(),
        .commits(commits),
        .branch(branch),
        .irqFlags(irqFlags),
        .irqSrc(irqSrc),
        .irqMemAddr(irqMemAddr),
        .halt(halt)
    );

endmodule

//--- design/uopDecode.sv
`timescale 1ns/1ps

module uopDecode import robPkg::*; import uopPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic instrValid,
    input  logic [31:0] instrPc,
    input  logic [31:0] instr,
    input  SqN curSqN,
    input  BranchProv branch,
    output DecUOp decUop,
    output logic stall
);

    InstrWord fields;
    Opcode op;
    SqN nextSqN;
    SqN inFlight;
    logic accept;

    assign fields = instr;

    // window is full once every buffer slot has a sequence number
    assign inFlight = nextSqN - curSqN;
    assign stall = inFlight == SqN'(RobLength);
    assign accept = instrValid && !stall;

    always_comb begin
        case (fields.opcode)
            OpAdd, OpMul, OpBranch, OpEbreak, OpEcall: op = Opcode'(fields.opcode);
            default: op = OpIllegal;
        endcase
    end

    always_ff @(posedge clk) begin
        decUop.opcode <= op;
        decUop.nmDst <= fields.nmDst;
        // tag follows the sequence number
        decUop.tagDst <= nextSqN;
        decUop.sqN <= nextSqN;
        decUop.pc <= instrPc;
        decUop.opA <= fields.opA;
        decUop.opB <= fields.opB;
        decUop.branchId <= fields.branchId;

        if (rst) begin
            nextSqN <= '0;
            decUop.valid <= 1'b0;
        end
        else if (branch.taken) begin
            // restart right after the redirecting instruction
            nextSqN <= branch.sqN + SqN'(1);
            decUop.valid <= 1'b0;
        end
        else begin
            decUop.valid <= accept;
            if (accept) begin
                nextSqN <= nextSqN + SqN'(1);
            end
        end
    end

endmodule

//--- execute/execUnits.sv
`timescale 1ns/1ps

module execUnits import robPkg::*; import uopPkg::*; (
    input  logic clk,
    input  logic rst,
    input  DecUOp decUop,
    input  BranchProv branch,
    output ResUOp wbUop [WbWidth-1:0]
);

    DecUOp mulIn;
    ResUOp aluOut;
    ResUOp mulOut;
    Flags aluFlags;
    logic toMul;
    logic isBr;

    assign toMul = decUop.opcode == OpMul;
    assign isBr = decUop.opcode == OpBranch;

    // steer multiplies away from the single-cycle lane
    always_comb begin
        mulIn = decUop;
        mulIn.valid = decUop.valid && toMul;
    end

    always_comb begin
        case (decUop.opcode)
            OpEbreak: aluFlags = FlagBreak;
            OpEcall: aluFlags = FlagTrap;
            OpIllegal: aluFlags = FlagExcept;
            default: aluFlags = FlagNone;
        endcase
    end

    always_ff @(posedge clk) begin
        aluOut.flags <= aluFlags;
        aluOut.nmDst <= decUop.nmDst;
        aluOut.tagDst <= decUop.tagDst;
        aluOut.sqN <= decUop.sqN;
        aluOut.pc <= decUop.pc;
        aluOut.isBranch <= isBr;
        // unsigned compare, also kept for exceptions as part of the fault address
        aluOut.branchTaken <= (isBr || aluFlags == FlagExcept) && (decUop.opA < decUop.opB);
        aluOut.branchId <= decUop.branchId;

        if (rst || branch.taken) begin
            aluOut.valid <= 1'b0;
        end
        else begin
            aluOut.valid <= decUop.valid && !toMul;
        end
    end

    mulLane mulUnit (
        .clk(clk),
        .rst(rst),
        .uopIn(mulIn),
        .flush(branch.taken),
        .wbOut(mulOut)
    );

    // port 0 is the fast lane, port 1 the multiplier
    assign wbUop[0] = aluOut;
    assign wbUop[1] = mulOut;

endmodule

//--- execute/mulLane.sv
`timescale 1ns/1ps

module mulLane import robPkg::*; import uopPkg::*; (
    input  logic clk,
    input  logic rst,
    input  DecUOp uopIn,
    input  logic flush,
    output ResUOp wbOut
);

    ResUOp stage [MulStages];
    ResUOp entering;

    // only the identity travels, the product itself is not modelled
    always_comb begin
        entering.valid = uopIn.valid;
        entering.flags = FlagNone;
        entering.nmDst = uopIn.nmDst;
        entering.tagDst = uopIn.tagDst;
        entering.sqN = uopIn.sqN;
        entering.pc = uopIn.pc;
        entering.isBranch = 1'b0;
        entering.branchTaken = 1'b0;
        entering.branchId = uopIn.branchId;
    end

    always_ff @(posedge clk) begin
        stage[0] <= entering;
        for (int s = 1; s < MulStages; s++) begin
            stage[s] <= stage[s-1];
        end

        // a redirect kills everything in flight
        if (rst || flush) begin
            for (int s = 0; s < MulStages; s++) begin
                stage[s].valid <= 1'b0;
            end
        end
    end

    assign wbOut = stage[MulStages-1];

endmodule

//--- project.f
common/robPkg.sv
common/uopPkg.sv
execute/mulLane.sv
execute/execUnits.sv
design/uopDecode.sv
rob/reorderBuffer.sv
design/backendTop.sv
verif/backendTb.sv

//--- rob/reorderBuffer.sv
`timescale 1ns/1ps

module reorderBuffer import robPkg::*; import uopPkg::*; (
    input  logic clk,
    input  logic rst,
    input  ResUOp wbUop [WbWidth-1:0],
    input  logic [31:0] irqAddr,
    output SqN curSqN,
    output SqN maxSqN,
    output CommitUOp commits [CommitWidth-1:0],
    output BranchProv branch,
    output Flags irqFlags,
    output logic [31:0] irqSrc,
    output logic [11:0] irqMemAddr,
    output logic halt
);

    typedef struct packed {
        logic valid;
        Flags flags;
        logic [4:0] nmDst;
        SqN tagDst;
        logic [31:0] pc;
        logic isBranch;
        logic branchTaken;
        logic [5:0] branchId;
    } RobEntry;

    // entry 0 is always the oldest instruction
    RobEntry entries [RobLength];
    RobEntry nextEntries [RobLength];
    SqN baseIdx;
    SqN newBase;
    logic headFlagged;
    logic dualOk;
    logic dropWb;
    logic [1:0] nCom;

    assign curSqN = baseIdx;
    assign maxSqN = baseIdx + SqN'(RobLength - 1);

    assign headFlagged = entries[0].valid && entries[0].flags != FlagNone;
    assign dualOk = entries[0].valid && entries[1].valid
        && entries[0].flags == FlagNone && entries[1].flags == FlagNone
        && !entries[1].isBranch;
    assign nCom = dualOk ? 2'd2 : (entries[0].valid ? 2'd1 : 2'd0);
    assign newBase = baseIdx + SqN'(nCom);

    // results arriving in the redirect cycle belong to flushed instructions
    assign dropWb = headFlagged || branch.taken;

    always_comb begin
        logic [RobIdxW-1:0] src;
        logic [RobIdxW-1:0] dst;

        // shift out the committed entries
        for (int i = 0; i < RobLength; i++) begin
            src = RobIdxW'(i) + RobIdxW'(nCom);
            nextEntries[i] = entries[src];
            if (i + int'(nCom) >= RobLength || headFlagged) begin
                nextEntries[i].valid = 1'b0;
            end
        end

        // insert relative to the base after this cycle's commit
        for (int p = 0; p < WbWidth; p++) begin
            dst = RobIdxW'(wbUop[p].sqN - newBase);
            if (wbUop[p].valid && !dropWb) begin
                nextEntries[dst].valid = 1'b1;
                nextEntries[dst].flags = wbUop[p].flags;
                nextEntries[dst].nmDst = wbUop[p].nmDst;
                nextEntries[dst].tagDst = wbUop[p].tagDst;
                nextEntries[dst].pc = wbUop[p].pc;
                nextEntries[dst].isBranch = wbUop[p].isBranch;
                nextEntries[dst].branchTaken = wbUop[p].branchTaken;
                nextEntries[dst].branchId = wbUop[p].branchId;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RobLength; i++) begin
            entries[i] <= nextEntries[i];
        end

        for (int k = 0; k < CommitWidth; k++) begin
            commits[k].valid <= k < int'(nCom);
            commits[k].nmDst <= entries[k].nmDst;
            commits[k].tagDst <= entries[k].tagDst;
            commits[k].sqN <= baseIdx + SqN'(k);
            commits[k].pc <= entries[k].pc;
            commits[k].isBranch <= entries[k].isBranch;
            commits[k].branchTaken <= entries[k].branchTaken;
            commits[k].branchId <= entries[k].branchId;
        end

        branch.taken <= 1'b0;
        halt <= 1'b0;

        // a flagged head commits alone and redirects fetch
        if (headFlagged) begin
            branch.taken <= 1'b1;
            branch.sqN <= baseIdx;
            branch.flush <= 1'b1;
            branch.storeSqN <= '0;
            branch.loadSqN <= '0;
            if (entries[0].flags == FlagBreak) begin
                // resume at the instruction after the ebreak
                halt <= 1'b1;
                branch.dstPc <= entries[0].pc + 32'd4;
                commits[0].nmDst <= '0;
            end
            else begin
                branch.dstPc <= irqAddr;
                irqFlags <= entries[0].flags;
                irqSrc <= entries[0].pc;
                irqMemAddr <= {entries[0].nmDst, entries[0].branchTaken, entries[0].branchId};
                if (entries[0].flags == FlagExcept) begin
                    commits[0].nmDst <= '0;
                end
            end
        end

        if (rst) begin
            baseIdx <= '0;
            for (int i = 0; i < RobLength; i++) begin
                entries[i].valid <= 1'b0;
            end
            for (int k = 0; k < CommitWidth; k++) begin
                commits[k].valid <= 1'b0;
            end
            branch.taken <= 1'b0;
            halt <= 1'b0;
            irqFlags <= FlagNone;
        end
        else begin
            baseIdx <= newBase;
        end
    end

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module backendTb -f project.f -o backendSim &&
./obj_dir/backendSim || exit 1

//--- verif/backendTb.sv
`timescale 1ns/1ps

module backendTb import robPkg::*; import uopPkg::*; ();

    localparam int CycleNs = 40;
    localparam int MixedCount = 300;
    localparam int FlagCount = 300;
    localparam int MulCount = 120;
    localparam int TotalInstr = MixedCount + FlagCount + MulCount;

    typedef struct packed {
        SqN sqN;
        logic [31:0] pc;
        logic [3:0] code;
        logic [4:0] nmDst;
        logic [7:0] opA;
        logic [7:0] opB;
        logic [5:0] branchId;
    } IssuedInstr;

    logic clk;
    logic rst;
    logic instrValid;
    logic [31:0] instrPc;
    logic [31:0] instr;
    logic [31:0] irqAddr;
    logic stall;
    CommitUOp commits [CommitWidth-1:0];
    BranchProv branch;
    Flags irqFlags;
    logic [31:0] irqSrc;
    logic [11:0] irqMemAddr;
    logic halt;

    // accepted but not yet committed, oldest first
    IssuedInstr pending [$];
    logic [31:0] seed;
    logic [31:0] pcCounter;
    SqN nextSqN;

    backendTop i_dut (.*);

    initial clk = 1'b0;
    always #(CycleNs / 2) clk = ~clk;

    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic isFlagCode(input logic [3:0] code);
        return !(code == 4'(OpAdd) || code == 4'(OpMul) || code == 4'(OpBranch));
    endfunction

    // ebreak and illegal opcodes commit with no destination
    function automatic logic dropsDst(input logic [3:0] code);
        return code == 4'(OpEbreak) || (isFlagCode(code) && code != 4'(OpEcall));
    endfunction

    // mode 0 mixed, mode 1 adds flag opcodes, mode 2 multiplies only
    function automatic logic [31:0] makeInstr(input int mode);
        logic [31:0] r;
        logic [31:0] f;
        logic [7:0] sel;
        logic [3:0] code;
        r = nextRand();
        f = nextRand();
        sel = r[7:0];
        code = (mode == 2 || (sel >= 8'd100 && sel < 8'd190)) ? 4'(OpMul)
            : (sel < 8'd100) ? 4'(OpAdd)
            : (mode == 0 || sel < 8'd215) ? 4'(OpBranch)
            : (sel < 8'd225) ? 4'(OpEbreak)
            : (sel < 8'd240) ? 4'(OpEcall)
            : 4'd5 + r[11:8] % 4'd11;
        return {code, f[27:0]};
    endfunction

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic expectEqual(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
            abortRun("output value mismatch");
        end
    endtask

    task automatic checkResetState();
        for (int k = 0; k < CommitWidth; k++) begin
            expectEqual($sformatf("commits[%0d].valid", k), 32'(commits[k].valid), 32'd0);
        end
        expectEqual("branch.taken", 32'(branch.taken), 32'd0);
        expectEqual("halt", 32'(halt), 32'd0);
        expectEqual("stall", 32'(stall), 32'd0);
    endtask

    task automatic checkCommit(input int k, input IssuedInstr exp);
        string port;
        port = $sformatf("commits[%0d]", k);
        expectEqual({port, ".sqN"}, 32'(commits[k].sqN), 32'(exp.sqN));
        expectEqual({port, ".tagDst"}, 32'(commits[k].tagDst), 32'(exp.sqN));
        expectEqual({port, ".pc"}, commits[k].pc, exp.pc);
        expectEqual({port, ".nmDst"}, 32'(commits[k].nmDst),
            dropsDst(exp.code) ? 32'd0 : 32'(exp.nmDst));
        expectEqual({port, ".isBranch"}, 32'(commits[k].isBranch),
            32'(exp.code == 4'(OpBranch)));
        expectEqual({port, ".branchId"}, 32'(commits[k].branchId), 32'(exp.branchId));
        if (exp.code == 4'(OpBranch)) begin
            expectEqual({port, ".branchTaken"}, 32'(commits[k].branchTaken),
                32'(exp.opA < exp.opB));
        end
        // second port never takes a branch or a flagged instruction
        if (k == 1) begin
            assert (exp.code != 4'(OpBranch) && !isFlagCode(exp.code))
                else abortRun("dual commit paired an instruction that must go alone");
        end
    endtask

    task automatic checkRedirect(input IssuedInstr exp);
        logic takenBit;
        // only an exception carries the compare result
        takenBit = exp.code != 4'(OpEcall) && exp.opA < exp.opB;
        expectEqual("branch.taken", 32'(branch.taken), 32'd1);
        expectEqual("branch.sqN", 32'(branch.sqN), 32'(exp.sqN));
        expectEqual("branch.flush", 32'(branch.flush), 32'd1);
        expectEqual("branch.loadSqN", 32'(branch.loadSqN), 32'd0);
        expectEqual("branch.storeSqN", 32'(branch.storeSqN), 32'd0);
        if (exp.code == 4'(OpEbreak)) begin
            expectEqual("halt", 32'(halt), 32'd1);
            expectEqual("branch.dstPc", branch.dstPc, exp.pc + 32'd4);
        end
        else begin
            expectEqual("halt", 32'(halt), 32'd0);
            expectEqual("branch.dstPc", branch.dstPc, irqAddr);
            expectEqual("irqSrc", irqSrc, exp.pc);
            expectEqual("irqFlags", 32'(irqFlags),
                exp.code == 4'(OpEcall) ? 32'(FlagTrap) : 32'(FlagExcept));
            expectEqual("irqMemAddr", 32'(irqMemAddr),
                32'({exp.nmDst, takenBit, exp.branchId}));
        end
    endtask

    task automatic checkOutputs();
        IssuedInstr head;
        logic redirected;
        redirected = 1'b0;
        assert (commits[0].valid || !commits[1].valid)
            else abortRun("commit port 1 valid while port 0 is idle");
        for (int k = 0; k < CommitWidth; k++) begin
            if (commits[k].valid) begin
                assert (pending.size() != 0) else abortRun("commit with nothing outstanding");
                head = pending.pop_front();
                checkCommit(k, head);
                if (isFlagCode(head.code)) begin
                    assert (k == 0 && !commits[1].valid)
                        else abortRun("flagged instruction did not commit alone");
                    checkRedirect(head);
                    redirected = 1'b1;
                end
            end
        end
        if (redirected) begin
            // younger instructions are flushed and fetch resumes at the target
            pending.delete();
            nextSqN = head.sqN + SqN'(1);
            pcCounter = head.code == 4'(OpEbreak) ? head.pc + 32'd4 : irqAddr;
            irqAddr = nextRand() & 32'hffff_fffc;
        end
        else begin
            expectEqual("branch.taken", 32'(branch.taken), 32'd0);
            expectEqual("halt", 32'(halt), 32'd0);
            // full window means RobLength instructions outstanding
            expectEqual("stall", 32'(stall), 32'(pending.size() == RobLength));
        end
    endtask

    // check the last cycle's outputs, then present the next input
    task automatic stepCycle(input logic valid, input logic [31:0] word, output logic accepted);
        IssuedInstr entry;
        @(negedge clk);
        checkOutputs();
        accepted = valid && !stall && !branch.taken;
        instrValid = valid;
        instr = word;
        instrPc = pcCounter;
        if (accepted) begin
            entry = {nextSqN, pcCounter, word[31:28], word[27:23], word[22:15], word[14:7],
                word[6:1]};
            pending.push_back(entry);
            nextSqN = nextSqN + SqN'(1);
            pcCounter = pcCounter + 32'd4;
        end
    endtask

    task automatic runStream(input int count, input int mode);
        logic [31:0] word;
        logic [31:0] r;
        logic valid;
        logic accepted;
        int done;
        done = 0;
        word = makeInstr(mode);
        while (done < count) begin
            r = nextRand();
            // the multiply burst holds instrValid high
            valid = mode == 2 || r[2:0] != 3'd0;
            stepCycle(valid, word, accepted);
            if (accepted) begin
                done++;
                word = makeInstr(mode);
            end
        end
    endtask

    initial begin
        logic idleTaken;
        seed = 32'h63fd;
        rst = 1'b1;
        instrValid = 1'b0;
        instrPc = '0;
        instr = '0;
        irqAddr = 32'h0000_4000;
        pcCounter = 32'h0000_1000;
        nextSqN = '0;
        repeat (4) begin
            @(negedge clk);
            checkResetState();
        end
        rst = 1'b0;
        @(negedge clk);
        checkResetState();
        runStream(MixedCount, 0);
        runStream(FlagCount, 1);
        runStream(MulCount, 2);
        // let in-flight work retire, then make sure nothing else commits
        for (int i = 0; i < 4 * RobLength && pending.size() != 0; i++) begin
            stepCycle(1'b0, 32'd0, idleTaken);
        end
        repeat (4) stepCycle(1'b0, 32'd0, idleTaken);
        if (pending.size() != 0) begin
            $display("%0d accepted instructions never committed", pending.size());
            $display("RESULT: FAIL");
            $fatal(1, "instructions lost");
        end
        else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

    // ten cycles per instruction is far beyond the slowest stream
    initial begin
        #(TotalInstr * CycleNs * 10);
        $display("watchdog expired before the test sequence finished");
        $display("RESULT: FAIL");
        $fatal(1, "timeout");
    end

endmodule
